/* bench/tb_rv_program.svh */
`ifndef tb_rv_program_svh
`define tb_rv_program_svh

// the program ends with ecall at word 33, the rest of the table is ecall padding
localparam int prog_len = 34;
localparam logic [31:0] nop = 32'h0000_0013;
localparam logic [31:0] ecall = 32'h0000_0073;

// first program word of each test, in test order
localparam int test_first [6] = '{0, 2, 12, 24, 30, 32};

logic [31:0] prog [64];

function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd);
  return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd);
  return {imm, rd, 7'b0110111};
endfunction

// the branch offset is a byte offset with bit 0 dropped by the encoding
function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

task automatic load_program();
  for (int i = 0; i < 64; i++) begin
    prog[i] = ecall;
  end
  // lui then addi on its result
  prog[0] = u_type(20'($urandom()), 5'd1);
  prog[1] = i_type(12'($urandom()), 5'd1, 3'd0, 5'd2);
  // x3 is built negative so that srai has sign bits to shift in
  prog[2] = u_type(20'($urandom()) | 20'h80000, 5'd3);
  prog[3] = i_type(12'($urandom()), 5'd3, 3'd0, 5'd3);
  prog[4] = i_type(12'($urandom()), 5'd3, 3'd2, 5'd4);
  prog[5] = i_type(12'($urandom()), 5'd3, 3'd3, 5'd5);
  prog[6] = i_type(12'($urandom()), 5'd3, 3'd4, 5'd6);
  prog[7] = i_type(12'($urandom()), 5'd3, 3'd6, 5'd7);
  prog[8] = i_type(12'($urandom()), 5'd3, 3'd7, 5'd8);
  prog[9] = i_type({7'h00, 5'($urandom_range(31, 1))}, 5'd3, 3'd1, 5'd9);
  prog[10] = i_type({7'h00, 5'($urandom_range(31, 1))}, 5'd3, 3'd5, 5'd10);
  prog[11] = i_type({7'h20, 5'($urandom_range(31, 1))}, 5'd3, 3'd5, 5'd11);
  // two random operands for add and sub
  prog[12] = u_type(20'($urandom()), 5'd12);
  prog[13] = i_type(12'($urandom()), 5'd12, 3'd0, 5'd12);
  prog[14] = u_type(20'($urandom()), 5'd13);
  prog[15] = i_type(12'($urandom()), 5'd13, 3'd0, 5'd13);
  prog[16] = r_type(7'h00, 5'd13, 5'd12, 3'd0, 5'd14);
  prog[17] = r_type(7'h20, 5'd13, 5'd12, 3'd0, 5'd15);
  // all ones plus one and zero minus one carry or borrow through every slice
  prog[18] = i_type(12'hfff, 5'd0, 3'd0, 5'd16);
  prog[19] = i_type(12'h001, 5'd0, 3'd0, 5'd18);
  prog[20] = r_type(7'h00, 5'd18, 5'd16, 3'd0, 5'd19);
  prog[21] = r_type(7'h20, 5'd18, 5'd0, 3'd0, 5'd20);
  prog[22] = u_type(20'h80000, 5'd21);
  prog[23] = r_type(7'h00, 5'd21, 5'd21, 3'd0, 5'd22);
  // taken beq and bne skip one word each, the next two fall through
  prog[24] = b_type(13'd8, 5'd18, 5'd18, 3'd0);
  prog[25] = i_type(12'h001, 5'd0, 3'd0, 5'd23);
  prog[26] = b_type(13'd8, 5'd16, 5'd18, 3'd1);
  prog[27] = i_type(12'h002, 5'd0, 3'd0, 5'd23);
  prog[28] = b_type(13'd8, 5'd16, 5'd18, 3'd0);
  prog[29] = b_type(13'd8, 5'd18, 5'd18, 3'd1);
  // write to x0, then read x0 as an operand
  prog[30] = i_type(12'($urandom()) | 12'h001, 5'd18, 3'd0, 5'd0);
  prog[31] = r_type(7'h00, 5'd18, 5'd0, 3'd0, 5'd24);
  // opcode 1010111 lies outside the kept subset
  prog[32] = 32'h0000_0057;
  prog[33] = ecall;
endtask

`endif

/* bench/tb_rv_core.sv */
`timescale 1ns/10ps

module tb_rv_core;

  logic clk;
  logic rst;
  logic [31:0] insn;
  logic [31:0] pc;
  logic halt;
  logic illegal;
  logic wb_en;
  logic [4:0] wb_rd;
  logic [31:0] wb_data;

  `include "tb_rv_program.svh"

  localparam int num_tests = 6;
  // every instruction retires in one cycle, so twice the program is a wide margin
  localparam int cycle_limit = 2 * prog_len + 20;
  localparam string test_names [num_tests] = '{"lui_addi", "reg_imm", "add_sub",
    "branch", "x0_write", "illegal_halt"};

  logic feed_on;
  int cycles;
  int err_count;
  int test_errs [num_tests];
  int cur_test;
  int done_tests;
  int bad_tests;

  // reference state and the expected outputs for the word now on insn
  logic [31:0] mregs [32];
  logic [31:0] mpc;
  logic exp_wb_en;
  logic [4:0] exp_rd;
  logic [31:0] exp_data;
  logic [31:0] exp_next_pc;
  logic exp_halt;
  logic exp_illegal;

  rv_core #(
    .reset_pc(32'h0)
  ) dut0 (
    .clk(clk),
    .rst(rst),
    .insn(insn),
    .pc(pc),
    .halt(halt),
    .illegal(illegal),
    .wb_en(wb_en),
    .wb_rd(wb_rd),
    .wb_data(wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // expected behavior taken straight from the RV32I instruction rules
  always_comb begin : model
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [4:0] sh;
    logic wr;

    a = mregs[insn[19:15]];
    b = mregs[insn[24:20]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    sh = insn[24:20];
    wr = 1'b0;
    exp_data = '0;
    exp_next_pc = mpc + 32'd4;
    exp_halt = 1'b0;
    exp_illegal = 1'b0;
    exp_rd = insn[11:7];
    case (insn[6:0])
      7'b0110111: begin
        wr = 1'b1;
        exp_data = {insn[31:12], 12'h000};
      end
      7'b0010011: begin
        wr = 1'b1;
        case (insn[14:12])
          3'd0: exp_data = a + imm_i;
          3'd2: exp_data = {31'b0, $signed(a) < $signed(imm_i)};
          3'd3: exp_data = {31'b0, a < imm_i};
          3'd4: exp_data = a ^ imm_i;
          3'd6: exp_data = a | imm_i;
          3'd7: exp_data = a & imm_i;
          3'd1: begin
            exp_data = a << sh;
            exp_illegal = (insn[31:25] != 7'h00);
          end
          default: begin
            // srli fills with zeros, srai with copies of bit 31
            if (insn[31:25] == 7'h00) begin
              exp_data = a >> sh;
            end else if (insn[31:25] == 7'h20) begin
              exp_data = $signed(a) >>> sh;
            end else begin
              exp_illegal = 1'b1;
            end
          end
        endcase
      end
      7'b0110011: begin
        wr = 1'b1;
        if (insn[14:12] == 3'd0 && insn[31:25] == 7'h00) begin
          exp_data = a + b;
        end else if (insn[14:12] == 3'd0 && insn[31:25] == 7'h20) begin
          exp_data = a - b;
        end else begin
          exp_illegal = 1'b1;
        end
      end
      7'b1100011: begin
        if (insn[14:12] == 3'd0) begin
          exp_next_pc = (a == b) ? mpc + imm_b : mpc + 32'd4;
        end else if (insn[14:12] == 3'd1) begin
          exp_next_pc = (a != b) ? mpc + imm_b : mpc + 32'd4;
        end else begin
          exp_illegal = 1'b1;
        end
      end
      7'b1110011: begin
        // ecall stops the core in place
        if (insn == ecall) begin
          exp_halt = 1'b1;
          exp_next_pc = mpc;
        end else begin
          exp_illegal = 1'b1;
        end
      end
      default: exp_illegal = 1'b1;
    endcase
    exp_wb_en = wr && !exp_illegal && (exp_rd != 5'd0);
  end

  // the model retires the same instruction as the core at every edge
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        mregs[i] <= '0;
      end
      mpc <= 32'h0;
    end else begin
      if (exp_wb_en) begin
        mregs[exp_rd] <= exp_data;
      end
      mpc <= exp_next_pc;
    end
  end

  task automatic value_err(string msg);
    $display("ERR %0t: %s", $time, msg);
    err_count++;
    test_errs[cur_test]++;
  endtask

  a_pc: assert property (@(posedge clk) disable iff (rst) pc == mpc)
    else value_err($sformatf("pc %h, expected %h", $sampled(pc), $sampled(mpc)));
  a_wb_en: assert property (@(posedge clk) disable iff (rst) wb_en == exp_wb_en)
    else value_err($sformatf("wb_en %b at pc %h", $sampled(wb_en), $sampled(pc)));
  a_wb_rd: assert property (@(posedge clk) disable iff (rst) exp_wb_en |-> wb_rd == exp_rd)
    else value_err($sformatf("wb_rd %0d, expected %0d", $sampled(wb_rd), $sampled(exp_rd)));
  a_wb_data: assert property (@(posedge clk) disable iff (rst)
    exp_wb_en |-> wb_data == exp_data)
    else value_err($sformatf("wb_data %h, expected %h at pc %h", $sampled(wb_data),
      $sampled(exp_data), $sampled(pc)));
  a_halt: assert property (@(posedge clk) disable iff (rst) halt == exp_halt)
    else value_err($sformatf("halt %b at pc %h", $sampled(halt), $sampled(pc)));
  a_illegal: assert property (@(posedge clk) disable iff (rst) illegal == exp_illegal)
    else value_err($sformatf("illegal %b at pc %h", $sampled(illegal), $sampled(pc)));

  function automatic int test_of(logic [31:0] addr);
    int k;
    k = 0;
    for (int t = 1; t < num_tests; t++) begin
      if (addr[31:2] >= test_first[t]) begin
        k = t;
      end
    end
    return k;
  endfunction

  task automatic finish_test(int t);
    if (test_errs[t] == 0) begin
      $display("test %0d %s: ok", t + 1, test_names[t]);
    end else begin
      $display("test %0d %s: %0d errors", t + 1, test_names[t], test_errs[t]);
      bad_tests++;
    end
    done_tests++;
  endtask

  // the word at the new pc goes onto insn shortly after each edge
  always @(posedge clk) begin
    #1;
    if (feed_on) begin
      insn = prog[pc[7:2]];
    end
  end

  // at the falling edge the checks of the last retired word are counted
  always @(negedge clk) begin
    if (!rst && feed_on && test_of(pc) != cur_test) begin
      finish_test(cur_test);
      cur_test = test_of(pc);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: the core did not halt within %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    rst = 1'b1;
    insn = nop;
    feed_on = 1'b0;
    cycles = 0;
    err_count = 0;
    cur_test = 0;
    done_tests = 0;
    bad_tests = 0;
    for (int t = 0; t < num_tests; t++) begin
      test_errs[t] = 0;
    end
    void'($urandom(29557));
    load_program();
    repeat (3) @(posedge clk);
    feed_on = 1'b1;
    #1 rst = 1'b0;
    do @(negedge clk); while (!halt);
    // a few more cycles show that pc holds and nothing is written after ecall
    repeat (3) @(negedge clk);
    finish_test(cur_test);
    $display("summary: %0d of %0d tests ran, %0d with errors, %0d value errors",
      done_tests, num_tests, bad_tests, err_count);
    if (err_count == 0 && done_tests == num_tests) begin
      $display("all tests passed");
    end else begin
      if (done_tests != num_tests) begin
        $display("only %0d of %0d tests ran to the end", done_tests, num_tests);
      end
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+bench
verilog/rv_pkg.sv
verilog/decode_if.sv
verilog/regfile_if.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_cla_adder.sv
verilog/rv_execute.sv
verilog/rv_core.sv
bench/tb_rv_core.sv

/* verilog/decode_if.sv */
`timescale 1ns/10ps

// decoded fields travel from the decoder to the execute unit in the same cycle
interface decode_if import rv_pkg::*; ();
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t imm;
  logic use_imm;
  alu_op_t alu_op;
  logic wr_en;
  logic is_branch;
  logic branch_ne;
  logic is_ecall;
  logic illegal;

  modport decoder (output rs1, rs2, rd, imm, use_imm, alu_op, wr_en, is_branch, branch_ne,
    is_ecall, illegal);
  modport execute (input rs1, rs2, rd, imm, use_imm, alu_op, wr_en, is_branch, branch_ne,
    is_ecall, illegal);
endinterface

/* verilog/regfile_if.sv */
`timescale 1ns/10ps

// read addresses come from the decoder, the write port from the execute unit
interface regfile_if import rv_pkg::*; ();
  reg_idx_t rs1_addr;
  reg_idx_t rs2_addr;
  word_t rs1_data;
  word_t rs2_data;
  reg_idx_t rd_addr;
  word_t rd_data;
  logic wr;

  modport read (output rs1_addr, rs2_addr);
  modport execute (input rs1_data, rs2_data, output rd_addr, rd_data, wr);
  modport regfile (input rs1_addr, rs2_addr, rd_addr, rd_data, wr, output rs1_data, rs2_data);
endinterface

/* verilog/rv_cla_adder.sv */
`timescale 1ns/10ps

module rv_cla_adder #(
  parameter int width = 32
) (
  input logic [width-1:0] a,
  input logic [width-1:0] b,
  input logic cin,
  output logic [width-1:0] sum
);

  localparam int groups = width / 4;

  logic [width-1:0] g;
  logic [width-1:0] p;
  logic [width-1:0] c;
  logic [groups-1:0] gc;

  if (width % 4 != 0) begin : gen_width_check
    $error("rv_cla_adder width must be a multiple of four");
  end

  // per-bit generate and propagate
  assign g = a & b;
  assign p = a ^ b;
  assign gc[0] = cin;

  for (genvar k = 0; k < groups; k++) begin : gen_group
    logic [3:0] gg;
    logic [3:0] pp;

    assign gg = g[4*k +: 4];
    assign pp = p[4*k +: 4];

    // carries inside the slice all come from the slice carry-in directly
    assign c[4*k] = gc[k];
    assign c[4*k+1] = gg[0] | (pp[0] & gc[k]);
    assign c[4*k+2] = gg[1] | (pp[1] & gg[0]) | (pp[1] & pp[0] & gc[k]);
    assign c[4*k+3] = gg[2] | (pp[2] & gg[1]) | (pp[2] & pp[1] & gg[0])
                      | (pp[2] & pp[1] & pp[0] & gc[k]);

    // group generate and propagate feed the ripple into the next slice
    if (k < groups - 1) begin : gen_next
      logic grp_g;
      logic grp_p;

      assign grp_g = gg[3] | (pp[3] & gg[2]) | (pp[3] & pp[2] & gg[1])
                     | (pp[3] & pp[2] & pp[1] & gg[0]);
      assign grp_p = &pp;
      assign gc[k+1] = grp_g | (grp_p & gc[k]);
    end
  end

  assign sum = p ^ c;

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/10ps

module rv_core import rv_pkg::*; #(
  parameter word_t reset_pc = '0
) (
  input logic clk,
  input logic rst,
  input insn_t insn,
  output word_t pc,
  output logic halt,
  output logic illegal,
  output logic wb_en,
  output reg_idx_t wb_rd,
  output word_t wb_data
);

  decode_if dec_bus ();
  regfile_if rf_bus ();

  rv_decoder u_decoder (
    .insn(insn),
    .dec(dec_bus.decoder),
    .rf(rf_bus.read)
  );

  rv_regfile u_regfile (
    .clk(clk),
    .rst(rst),
    .rf(rf_bus.regfile)
  );

  rv_execute #(
    .reset_pc(reset_pc)
  ) u_execute (
    .clk(clk),
    .rst(rst),
    .dec(dec_bus.execute),
    .rf(rf_bus.execute),
    .pc(pc),
    .halt(halt),
    .illegal(illegal)
  );

  // write-back view of the instruction on insn, it commits at the next edge
  assign wb_en = rf_bus.wr;
  assign wb_rd = rf_bus.rd_addr;
  assign wb_data = rf_bus.rd_data;

endmodule

/* verilog/rv_decoder.sv */
`timescale 1ns/10ps

module rv_decoder import rv_pkg::*; (
  input insn_t insn,
  decode_if.decoder dec,
  regfile_if.read rf
);

  opcode_t opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t rd;
  word_t imm_i;
  word_t imm_b;
  word_t imm_u;
  logic wr;

  // fixed field positions of the base encoding
  assign opcode = insn[6:0];
  assign rd = insn[11:7];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // sign-extended I, B and U immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // register reads start as soon as the fields are split
  assign rf.rs1_addr = insn[19:15];
  assign rf.rs2_addr = insn[24:20];
  assign dec.rs1 = insn[19:15];
  assign dec.rs2 = insn[24:20];
  assign dec.rd = rd;

  always_comb begin
    dec.imm = imm_i;
    dec.use_imm = 1'b0;
    dec.alu_op = alu_add;
    dec.is_branch = 1'b0;
    dec.branch_ne = 1'b0;
    dec.is_ecall = 1'b0;
    dec.illegal = 1'b0;
    wr = 1'b0;
    case (opcode)
      op_lui: begin
        dec.imm = imm_u;
        dec.alu_op = alu_pass_imm;
        wr = 1'b1;
      end
      op_reg_imm: begin
        // the shift amount sits in the low five bits of the I immediate
        dec.use_imm = 1'b1;
        wr = 1'b1;
        case (funct3)
          f3_add: dec.alu_op = alu_add;
          f3_slt: dec.alu_op = alu_slt;
          f3_sltu: dec.alu_op = alu_sltu;
          f3_xor: dec.alu_op = alu_xor;
          f3_or: dec.alu_op = alu_or;
          f3_and: dec.alu_op = alu_and;
          f3_sll: begin
            dec.alu_op = alu_sll;
            if (funct7 != funct7_base) begin
              dec.illegal = 1'b1;
              wr = 1'b0;
            end
          end
          default: begin
            // srli and srai share funct3 and differ in funct7
            if (funct7 == funct7_base) begin
              dec.alu_op = alu_srl;
            end else if (funct7 == funct7_alt) begin
              dec.alu_op = alu_sra;
            end else begin
              dec.illegal = 1'b1;
              wr = 1'b0;
            end
          end
        endcase
      end
      op_reg_reg: begin
        // only add and sub are kept from this group
        if (funct3 == f3_add && funct7 == funct7_base) begin
          dec.alu_op = alu_add;
          wr = 1'b1;
        end else if (funct3 == f3_add && funct7 == funct7_alt) begin
          dec.alu_op = alu_sub;
          wr = 1'b1;
        end else begin
          dec.illegal = 1'b1;
        end
      end
      op_branch: begin
        dec.imm = imm_b;
        if (funct3 == f3_beq || funct3 == f3_bne) begin
          dec.is_branch = 1'b1;
          dec.branch_ne = (funct3 == f3_bne);
        end else begin
          dec.illegal = 1'b1;
        end
      end
      op_environ: begin
        // ecall is the all-zero system encoding, anything else is rejected
        if (insn[31:7] == '0) begin
          dec.is_ecall = 1'b1;
        end else begin
          dec.illegal = 1'b1;
        end
      end
      default: dec.illegal = 1'b1;
    endcase
    // x0 is never written
    dec.wr_en = wr && (rd != '0);
  end

  // an instruction rejected anywhere in the case tree must not reach the write port
  always_comb begin
    assert final (!(dec.illegal && dec.wr_en))
      else $error("decoder raised illegal and wr_en together");
  end

endmodule

/* verilog/rv_execute.sv */
`timescale 1ns/10ps

module rv_execute import rv_pkg::*; #(
  parameter word_t reset_pc = '0
) (
  input logic clk,
  input logic rst,
  decode_if.execute dec,
  regfile_if.execute rf,
  output word_t pc,
  output logic halt,
  output logic illegal
);

  word_t op_a;
  word_t op_b;
  word_t add_b;
  word_t add_sum;
  word_t result;
  word_t next_pc;
  shamt_t shamt;
  logic is_sub;
  logic equal;
  logic taken;

  // second operand is the immediate for the register-immediate group
  assign op_a = rf.rs1_data;
  assign op_b = dec.use_imm ? dec.imm : rf.rs2_data;
  assign shamt = op_b[4:0];

  // sub is formed as a plus the inverted operand plus one
  assign is_sub = (dec.alu_op == alu_sub);
  assign add_b = is_sub ? ~op_b : op_b;

  rv_cla_adder #(
    .width(xlen)
  ) u_adder (
    .a(op_a),
    .b(add_b),
    .cin(is_sub),
    .sum(add_sum)
  );

  always_comb begin
    case (dec.alu_op)
      alu_add, alu_sub: result = add_sum;
      alu_slt: result = word_t'($signed(op_a) < $signed(op_b));
      alu_sltu: result = word_t'(op_a < op_b);
      alu_xor: result = op_a ^ op_b;
      alu_or: result = op_a | op_b;
      alu_and: result = op_a & op_b;
      alu_sll: result = op_a << shamt;
      alu_srl: result = op_a >> shamt;
      alu_sra: result = word_t'($signed(op_a) >>> shamt);
      default: result = dec.imm;
    endcase
  end

  // the write port follows the decoder, which already masks x0 and illegal
  assign rf.rd_addr = dec.rd;
  assign rf.rd_data = result;
  assign rf.wr = dec.wr_en;

  assign halt = dec.is_ecall;
  assign illegal = dec.illegal;

  // beq takes the branch on equal, bne on not equal
  assign equal = (rf.rs1_data == rf.rs2_data);
  assign taken = dec.is_branch && (equal ^ dec.branch_ne);

  always_comb begin
    if (halt) begin
      next_pc = pc;
    end else if (taken) begin
      next_pc = pc + dec.imm;
    end else begin
      next_pc = pc + 32'd4;
    end
  end

  // one instruction retires at every edge outside reset
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc lost its word alignment");

endmodule

/* verilog/rv_pkg.sv */
package rv_pkg;

  // data path width of the integer core
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [6:0] opcode_t;
  typedef logic [4:0] shamt_t;
  typedef logic [3:0] alu_op_t;

  // major opcodes of the kept subset, all with the low two bits set
  localparam opcode_t op_lui = 7'b01_101_11;
  localparam opcode_t op_reg_imm = 7'b00_100_11;
  localparam opcode_t op_reg_reg = 7'b01_100_11;
  localparam opcode_t op_branch = 7'b11_000_11;
  localparam opcode_t op_environ = 7'b11_100_11;

  // funct3 values, shared by the register-immediate and register-register groups
  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_sll = 3'b001;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_srl = 3'b101;
  localparam logic [2:0] f3_or = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // funct3 values of the two kept branches
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;

  // funct7 is all zero for the base ops, and bit 30 marks sub and srai
  localparam logic [6:0] funct7_base = 7'b000_0000;
  localparam logic [6:0] funct7_alt = 7'b010_0000;

  // ALU operation codes
  localparam alu_op_t alu_add = 4'd0;
  localparam alu_op_t alu_sub = 4'd1;
  localparam alu_op_t alu_slt = 4'd2;
  localparam alu_op_t alu_sltu = 4'd3;
  localparam alu_op_t alu_xor = 4'd4;
  localparam alu_op_t alu_or = 4'd5;
  localparam alu_op_t alu_and = 4'd6;
  localparam alu_op_t alu_sll = 4'd7;
  localparam alu_op_t alu_srl = 4'd8;
  localparam alu_op_t alu_sra = 4'd9;
  // lui writes the U immediate straight through
  localparam alu_op_t alu_pass_imm = 4'd10;

endpackage

/* verilog/rv_regfile.sv */
`timescale 1ns/10ps

module rv_regfile import rv_pkg::*; (
  input logic clk,
  input logic rst,
  regfile_if.regfile rf
);

  word_t regs [32];

  // reads are combinational and x0 always reads as zero
  assign rf.rs1_data = (rf.rs1_addr == '0) ? '0 : regs[rf.rs1_addr];
  assign rf.rs2_data = (rf.rs2_addr == '0) ? '0 : regs[rf.rs2_addr];

  // a write shows on the read ports from the next cycle on
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.wr) begin
      regs[rf.rd_addr] <= rf.rd_data;
    end
  end

  // the decoder masks writes to x0 before they reach this port
  a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
    rf.wr |-> rf.rd_addr != '0)
    else $error("write to x0 reached the register file");

endmodule
